// ==== logic/ob_consts.svh ====
`ifndef OB_CONSTS_SVH
`define OB_CONSTS_SVH

// Number of entries in one side of the book
`define OB_TABLE_N 17

// Inputs to the carry-save tree per round
`define OB_CSA_N 8

// Table muxes, two tree inputs go to the sum and carry accumulators
`define OB_MUX_N (`OB_CSA_N - 2)

// Rounds to cover the table, slots past the last entry read as zero
`define OB_ROUNDS_N ((`OB_TABLE_N + `OB_MUX_N - 1) / `OB_MUX_N)

// BCD digits in a price
`define OB_PRICE_DIGITS 4

// Quantity of one entry, and the accumulated total (17 x 255 fits in 13 bits)
`define OB_QTY_W 8
`define OB_ACC_W 13

`endif

// ==== logic/ob_book_pkg.sv ====
`include "ob_consts.svh"

package ob_book_pkg;

  // One BCD digit, 0 to 9
  typedef logic [3:0] bcd_digit_t;

  // Price as packed BCD, most significant digit on top
  // Digit order matches numeric order, so plain unsigned compares work
  typedef bcd_digit_t [`OB_PRICE_DIGITS-1:0] price_t;

  // Resting quantity of one table entry
  typedef logic [`OB_QTY_W-1:0] quantity_t;

  // Running total and command goal
  typedef logic [`OB_ACC_W-1:0] accum_quantity_t;

endpackage

// ==== logic/ob_count_pkg.sv ====
package ob_count_pkg;

  // Sequencer state
  // Top bit is the busy flag, so busy comes straight off the encoding
  typedef enum logic [4:0] {
    IDLE  = 5'b0_0000,
    // Rounds of table muxing
    ACCUM = 5'b1_0001,
    // Last round still in the staging register
    WAIT0 = 5'b1_0010,
    // Result settles in the accumulators
    WAIT1 = 5'b1_0011
  } count_state_t;

endpackage

// ==== logic/ob_csa_tree.sv ====
`include "ob_consts.svh"

module ob_csa_tree (
  input  ob_book_pkg::accum_quantity_t [`OB_CSA_N-1:0] addends,
  output ob_book_pkg::accum_quantity_t                 sum,
  output ob_book_pkg::accum_quantity_t                 carry
);
  import ob_book_pkg::*;

  accum_quantity_t [5:0] lvl1;
  accum_quantity_t [3:0] lvl2;
  accum_quantity_t [2:0] lvl3;

  // Full adder per bit, carry moved up one place and the top bit dropped
  function automatic void csa32(input accum_quantity_t a, input accum_quantity_t b,
                                input accum_quantity_t c, output accum_quantity_t s,
                                output accum_quantity_t co);
    s  = a ^ b ^ c;
    co = ((a & b) | (a & c) | (b & c)) << 1;
  endfunction

  // Tree wiring is fixed for eight inputs
  if (`OB_CSA_N != 8) begin : g_bad_degree
    $error("ob_csa_tree is wired for eight addends");
  end

  always_comb begin
    // 8 to 6
    csa32(addends[0], addends[1], addends[2], lvl1[0], lvl1[1]);
    csa32(addends[3], addends[4], addends[5], lvl1[2], lvl1[3]);
    lvl1[4] = addends[6];
    lvl1[5] = addends[7];
    // 6 to 4
    csa32(lvl1[0], lvl1[1], lvl1[2], lvl2[0], lvl2[1]);
    csa32(lvl1[3], lvl1[4], lvl1[5], lvl2[2], lvl2[3]);
    // 4 to 3
    csa32(lvl2[0], lvl2[1], lvl2[2], lvl3[0], lvl3[1]);
    lvl3[2] = lvl2[3];
    // 3 to 2, left redundant for the accumulator
    csa32(lvl3[0], lvl3[1], lvl3[2], sum, carry);
  end

endmodule

// ==== logic/ob_entry_select.sv ====
`include "ob_consts.svh"

module ob_entry_select #(
  parameter bit IS_ASK = 1'b1
) (
  input  logic                                       clk,
  input  ob_book_pkg::price_t    [`OB_TABLE_N-1:0]   tbl_price,
  input  ob_book_pkg::quantity_t [`OB_TABLE_N-1:0]   tbl_quantity,
  input  logic                   [`OB_TABLE_N-1:0]   tbl_vld,
  input  ob_book_pkg::price_t                        ctx_price,
  input  logic                   [`OB_ROUNDS_N-1:0]  round_sel,
  input  logic                                       stage_en,
  output ob_book_pkg::quantity_t [`OB_MUX_N-1:0]     lane_qty
);
  import ob_book_pkg::*;

  quantity_t [`OB_TABLE_N-1:0]                  entry_qty;
  quantity_t [`OB_MUX_N-1:0][`OB_ROUNDS_N-1:0]  slot_qty;
  quantity_t [`OB_MUX_N-1:0]                    lane_nxt;

  // Qualify each entry once, a blocked entry contributes zero
  for (genvar i = 0; i < `OB_TABLE_N; i++) begin : g_entry
    logic crosses;
    if (IS_ASK) begin : g_ask
      // Buyer reaches asks at or below the command price
      assign crosses = (tbl_price[i] <= ctx_price);
    end else begin : g_bid
      // Seller reaches bids at or above the command price
      assign crosses = (tbl_price[i] >= ctx_price);
    end
    assign entry_qty[i] = (tbl_vld[i] && crosses) ? tbl_quantity[i] : '0;
  end

  // Highest index in lane 0 of round 0, lanes fill before rounds
  for (genvar r = 0; r < `OB_ROUNDS_N; r++) begin : g_round
    for (genvar l = 0; l < `OB_MUX_N; l++) begin : g_lane
      localparam int IDX = `OB_TABLE_N - 1 - (r * `OB_MUX_N + l);
      if (IDX >= 0) begin : g_used
        assign slot_qty[l][r] = entry_qty[IDX];
      end else begin : g_pad
        // Past the table end
        assign slot_qty[l][r] = '0;
      end
    end
  end

  // One-hot AND-OR mux per lane
  always_comb begin
    lane_nxt = '0;
    for (int l = 0; l < `OB_MUX_N; l++) begin
      for (int r = 0; r < `OB_ROUNDS_N; r++) begin
        lane_nxt[l] = lane_nxt[l] | (slot_qty[l][r] & {`OB_QTY_W{round_sel[r]}});
      end
    end
  end

  // Staging register in front of the tree
  always_ff @(posedge clk) begin
    if (stage_en) begin
      lane_qty <= lane_nxt;
    end
  end

  a_sel_onehot: assert property (@(posedge clk) stage_en |-> $onehot(round_sel));

endmodule

// ==== logic/ob_accum.sv ====
`include "ob_consts.svh"

module ob_accum (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  ob_book_pkg::quantity_t [`OB_MUX_N-1:0]       lane_qty,
  input  logic                                         acc_init,
  input  logic                                         acc_upt,
  input  ob_book_pkg::accum_quantity_t                 ctx_goal,
  output ob_book_pkg::accum_quantity_t                 rsp_quantity,
  output logic                                         rsp_attained
);
  import ob_book_pkg::*;

  // Whole table at full quantity
  localparam int QTY_CEIL = `OB_TABLE_N * ((1 << `OB_QTY_W) - 1);

  accum_quantity_t [`OB_CSA_N-1:0] addends;
  accum_quantity_t                 sum_q;
  accum_quantity_t                 carry_q;
  accum_quantity_t                 sum_nxt;
  accum_quantity_t                 carry_nxt;

  // Lanes zero extended, then last round's redundant pair fed back
  always_comb begin
    for (int i = 0; i < `OB_MUX_N; i++) begin
      addends[i] = accum_quantity_t'(lane_qty[i]);
    end
    addends[`OB_CSA_N-2] = sum_q;
    addends[`OB_CSA_N-1] = carry_q;
  end

  ob_csa_tree u_csa_tree (
    .addends (addends),
    .sum     (sum_nxt),
    .carry   (carry_nxt)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q   <= '0;
      carry_q <= '0;
    end else if (acc_init) begin
      sum_q   <= '0;
      carry_q <= '0;
    end else if (acc_upt) begin
      sum_q   <= sum_nxt;
      carry_q <= carry_nxt;
    end
  end

  // Single carry-propagate add resolves the redundant form
  assign rsp_quantity = sum_q + carry_q;
  assign rsp_attained = (rsp_quantity >= ctx_goal);

  a_qty_ceil: assert property (@(posedge clk) disable iff (!rst_n)
    int'(rsp_quantity) <= QTY_CEIL);

endmodule

// ==== logic/ob_count_ctrl.sv ====
`include "ob_consts.svh"

module ob_count_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cmd_vld,
  input  ob_book_pkg::price_t          cmd_price,
  input  ob_book_pkg::quantity_t       cmd_quantity,
  output logic                         busy,
  output ob_book_pkg::price_t          ctx_price,
  output ob_book_pkg::accum_quantity_t ctx_goal,
  output logic [`OB_ROUNDS_N-1:0]      round_sel,
  output logic                         stage_en,
  output logic                         acc_init,
  output logic                         acc_upt
);
  import ob_book_pkg::*;
  import ob_count_pkg::*;

  count_state_t state_q;
  count_state_t state_nxt;
  logic         accept;
  logic         last_round;

  // Commands only land while idle, anything else is dropped
  assign accept     = (state_q == IDLE) && cmd_vld;
  assign last_round = round_sel[`OB_ROUNDS_N-1];

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      IDLE: begin
        if (cmd_vld) begin
          state_nxt = ACCUM;
        end
      end
      ACCUM: begin
        if (last_round) begin
          state_nxt = WAIT0;
        end
      end
      WAIT0:   state_nxt = WAIT1;
      WAIT1:   state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  // Busy follows the next state, so it rises with the accepted strobe
  assign busy = state_nxt[$bits(count_state_t)-1];

  // Stage every round; the accumulator trails the staging register by one
  assign stage_en = (state_q == ACCUM);
  assign acc_init = accept;
  assign acc_upt  = ((state_q == ACCUM) && !round_sel[0]) || (state_q == WAIT0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      round_sel <= '0;
      ctx_price <= '0;
      ctx_goal  <= '0;
    end else begin
      state_q <= state_nxt;
      // Round pointer walks one lane group per cycle, drops out after the last
      if (accept) begin
        round_sel <= `OB_ROUNDS_N'(1);
      end else if (stage_en) begin
        round_sel <= round_sel << 1;
      end
      // Context held for the whole command and the response after it
      if (accept) begin
        ctx_price <= cmd_price;
        ctx_goal  <= accum_quantity_t'(cmd_quantity);
      end
    end
  end

  a_round_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ACCUM) |-> $onehot(round_sel));

  a_init_upt_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(acc_init && acc_upt));

endmodule

// ==== logic/ob_count_top.sv ====
`include "ob_consts.svh"

module ob_count_top #(
  parameter bit IS_ASK = 1'b1
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     cmd_vld,
  input  ob_book_pkg::price_t                      cmd_price,
  input  ob_book_pkg::quantity_t                   cmd_quantity,
  input  ob_book_pkg::price_t    [`OB_TABLE_N-1:0] tbl_price,
  input  ob_book_pkg::quantity_t [`OB_TABLE_N-1:0] tbl_quantity,
  input  logic                   [`OB_TABLE_N-1:0] tbl_vld,
  output logic                                     busy,
  output ob_book_pkg::accum_quantity_t             rsp_quantity,
  output logic                                     rsp_attained
);
  import ob_book_pkg::*;

  // Control to datapath
  price_t                      ctx_price;
  accum_quantity_t             ctx_goal;
  logic [`OB_ROUNDS_N-1:0]     round_sel;
  logic                        stage_en;
  logic                        acc_init;
  logic                        acc_upt;
  // Staged lanes into the tree
  quantity_t [`OB_MUX_N-1:0]   lane_qty;

  ob_count_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_vld      (cmd_vld),
    .cmd_price    (cmd_price),
    .cmd_quantity (cmd_quantity),
    .busy         (busy),
    .ctx_price    (ctx_price),
    .ctx_goal     (ctx_goal),
    .round_sel    (round_sel),
    .stage_en     (stage_en),
    .acc_init     (acc_init),
    .acc_upt      (acc_upt)
  );

  ob_entry_select #(.IS_ASK(IS_ASK)) u_select (
    .clk          (clk),
    .tbl_price    (tbl_price),
    .tbl_quantity (tbl_quantity),
    .tbl_vld      (tbl_vld),
    .ctx_price    (ctx_price),
    .round_sel    (round_sel),
    .stage_en     (stage_en),
    .lane_qty     (lane_qty)
  );

  ob_accum u_accum (
    .clk          (clk),
    .rst_n        (rst_n),
    .lane_qty     (lane_qty),
    .acc_init     (acc_init),
    .acc_upt      (acc_upt),
    .ctx_goal     (ctx_goal),
    .rsp_quantity (rsp_quantity),
    .rsp_attained (rsp_attained)
  );

endmodule

// ==== bench/tb_clk_gen.sv ====
module tb_clk_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset drops just after an edge, like the other DUT inputs
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== bench/tb_count_checker.sv ====
`include "ob_consts.svh"

module tb_count_checker (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         busy,
  input  ob_book_pkg::accum_quantity_t rsp_quantity,
  input  logic                         rsp_attained,
  input  ob_book_pkg::accum_quantity_t exp_quantity,
  input  logic                         exp_attained,
  input  int                           vec_idx,
  output int                           error_count,
  output int                           check_count
);
  import ob_book_pkg::*;

  // Falling clock edges with busy high per command
  localparam int BUSY_CYCLES = `OB_ROUNDS_N + 2;
  localparam int BUSY_LIMIT  = 2 * BUSY_CYCLES;

  int   errors   = 0;
  int   checks   = 0;
  int   busy_len = 0;
  logic busy_d   = 1'b0;
  logic stuck    = 1'b0;
  // Set from a result until the next command starts
  logic hold_vld = 1'b0;

  assign error_count = errors;
  assign check_count = checks;

  task automatic check_value(input string what, input int expected, input int actual);
    if (actual != expected) begin
      $display("FAILED vector %0d %s: expected %0d, actual %0d",
               vec_idx, what, expected, actual);
      errors++;
    end
  endtask

  // Outputs are settled in mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (busy) begin
        busy_len++;
        hold_vld = 1'b0;
        if (busy_len > BUSY_LIMIT && !stuck) begin
          $display("busy stayed high for more than %0d cycles in vector %0d",
                   BUSY_LIMIT, vec_idx);
          errors++;
          stuck = 1'b1;
        end
      end else if (busy_d) begin
        // Result is due as busy falls
        checks++;
        check_value("busy cycles", BUSY_CYCLES, busy_len);
        check_value("quantity", int'(exp_quantity), int'(rsp_quantity));
        check_value("attained", int'(exp_attained), int'(rsp_attained));
        hold_vld = 1'b1;
        busy_len = 0;
        stuck    = 1'b0;
      end else if (hold_vld) begin
        // Result must hold while idle
        check_value("held quantity", int'(exp_quantity), int'(rsp_quantity));
        check_value("held attained", int'(exp_attained), int'(rsp_attained));
      end
      busy_d = busy;
    end
  end

endmodule

// ==== bench/tb_ob_count.sv ====
`include "ob_consts.svh"

module tb_ob_count;
  import ob_book_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int RST_CYCLES  = 8;
  // Six header words, then price and quantity per entry
  localparam int VEC_WORDS   = 6 + 2 * `OB_TABLE_N;
  localparam int VEC_MAX     = 16;
  localparam int BUSY_WAIT   = 4 * (`OB_ROUNDS_N + 2);
  // Idle cycles after each result
  localparam int HOLD_CYCLES = 3;

  logic                        clk;
  logic                        rst_n;
  logic                        cmd_vld;
  price_t                      cmd_price;
  quantity_t                   cmd_quantity;
  price_t    [`OB_TABLE_N-1:0] tbl_price;
  quantity_t [`OB_TABLE_N-1:0] tbl_quantity;
  logic      [`OB_TABLE_N-1:0] tbl_vld;
  logic                        busy;
  accum_quantity_t             rsp_quantity;
  logic                        rsp_attained;

  // Expected response of the vector in flight
  accum_quantity_t exp_quantity;
  logic            exp_attained;
  int              vec_idx;
  int              chk_errors;
  int              chk_count;
  int              tb_errors;
  int              n_vec;
  bit              loaded;
  logic [31:0]     vec_mem [0:VEC_WORDS*VEC_MAX-1];

  tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ob_count_top #(.IS_ASK(1'b1)) UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_vld      (cmd_vld),
    .cmd_price    (cmd_price),
    .cmd_quantity (cmd_quantity),
    .tbl_price    (tbl_price),
    .tbl_quantity (tbl_quantity),
    .tbl_vld      (tbl_vld),
    .busy         (busy),
    .rsp_quantity (rsp_quantity),
    .rsp_attained (rsp_attained)
  );

  tb_count_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .busy         (busy),
    .rsp_quantity (rsp_quantity),
    .rsp_attained (rsp_attained),
    .exp_quantity (exp_quantity),
    .exp_attained (exp_attained),
    .vec_idx      (vec_idx),
    .error_count  (chk_errors),
    .check_count  (chk_count)
  );

  // Inputs change a little after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic load_vectors();
    int i;
    // Unused words carry bit 31 above their address, out of reach of any mask
    for (i = 0; i < VEC_WORDS * VEC_MAX; i++) begin
      vec_mem[i] = 32'h8000_0000 | 32'(i);
    end
    $readmemh("bench/count_input.txt", vec_mem);
    n_vec = 0;
    while (n_vec < VEC_MAX && !vec_mem[n_vec*VEC_WORDS][31]) begin
      n_vec++;
    end
    if (n_vec == 0) begin
      $display("no vectors found in bench/count_input.txt");
      tb_errors++;
    end
    loaded = 1'b1;
  endtask

  task automatic run_vector(input int v);
    int   base;
    int   e;
    int   waited;
    logic second;
    base         = v * VEC_WORDS;
    vec_idx      = v;
    tbl_vld      = vec_mem[base][`OB_TABLE_N-1:0];
    cmd_price    = vec_mem[base+1][15:0];
    cmd_quantity = vec_mem[base+2][`OB_QTY_W-1:0];
    exp_quantity = vec_mem[base+3][`OB_ACC_W-1:0];
    exp_attained = vec_mem[base+4][0];
    second       = vec_mem[base+5][0];
    for (e = 0; e < `OB_TABLE_N; e++) begin
      tbl_price[e]    = vec_mem[base+6+2*e][15:0];
      tbl_quantity[e] = vec_mem[base+7+2*e][`OB_QTY_W-1:0];
    end
    cmd_vld = 1'b1;
    step_cycle();
    cmd_vld = 1'b0;
    // Stray command mid-count that would change the total if taken
    if (second) begin
      step_cycle();
      cmd_price    = 16'h9999;
      cmd_quantity = '0;
      cmd_vld      = 1'b1;
      step_cycle();
      cmd_vld = 1'b0;
    end
    waited = 0;
    while (busy && waited < BUSY_WAIT) begin
      step_cycle();
      waited++;
    end
    repeat (HOLD_CYCLES) step_cycle();
  endtask

  task automatic report_counts();
    $display("checks %0d, errors %0d", chk_count, chk_errors + tb_errors);
  endtask

  initial begin
    cmd_vld      = 1'b0;
    cmd_price    = '0;
    cmd_quantity = '0;
    tbl_price    = '0;
    tbl_quantity = '0;
    tbl_vld      = '0;
    exp_quantity = '0;
    exp_attained = 1'b0;
    vec_idx      = 0;
    tb_errors    = 0;
    loaded       = 1'b0;
    load_vectors();
    wait (rst_n);
    step_cycle();
    for (int v = 0; v < n_vec; v++) begin
      run_vector(v);
    end
    step_cycle();
    if (chk_count != n_vec) begin
      $display("%0d results checked for %0d vectors", chk_count, n_vec);
      tb_errors++;
    end
    report_counts();
    if (chk_errors + tb_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    wait (loaded);
    #(RST_CYCLES * CLK_PERIOD + n_vec * (`OB_ROUNDS_N + 6) * CLK_PERIOD);
    $display("timeout: run did not finish in time, stopped in vector %0d", vec_idx);
    report_counts();
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== bench/count_input.txt ====
// mask cmd_price goal exp_total exp_flag second_pulse, then price qty for entries 0..5
// next line: price qty for entries 6..16 (all hex)
1dffb 1025 6b 006c 1 0 1000 0a 1050 14 0995 05 1100 1e 1020 07 0990 03
1200 40 1005 0c 1030 08 0980 11 1010 09 1500 ff 1025 06 1001 02 0999 0b 1040 0d 1025 21
1dffb 1025 6c 006c 1 0 1000 0a 1050 14 0995 05 1100 1e 1020 07 0990 03
1200 40 1005 0c 1030 08 0980 11 1010 09 1500 ff 1025 06 1001 02 0999 0b 1040 0d 1025 21
1dffb 1025 6d 006c 0 0 1000 0a 1050 14 0995 05 1100 1e 1020 07 0990 03
1200 40 1005 0c 1030 08 0980 11 1010 09 1500 ff 1025 06 1001 02 0999 0b 1040 0d 1025 21
1ffff 1025 73 0073 1 0 1000 0a 1050 14 0995 05 1100 1e 1020 07 0990 03
1200 40 1005 0c 1030 08 0980 11 1010 09 1500 ff 1025 06 1001 02 0999 0b 1040 0d 1025 21
1dffb 0999 10 001f 1 1 1000 0a 1050 14 0995 05 1100 1e 1020 07 0990 03
1200 40 1005 0c 1030 08 0980 11 1010 09 1500 ff 1025 06 1001 02 0999 0b 1040 0d 1025 21
00000 9999 00 0000 1 0 1000 0a 1050 14 0995 05 1100 1e 1020 07 0990 03
1200 40 1005 0c 1030 08 0980 11 1010 09 1500 ff 1025 06 1001 02 0999 0b 1040 0d 1025 21
00000 9999 01 0000 0 0 1000 0a 1050 14 0995 05 1100 1e 1020 07 0990 03
1200 40 1005 0c 1030 08 0980 11 1010 09 1500 ff 1025 06 1001 02 0999 0b 1040 0d 1025 21
1ffff 9999 ff 10ef 1 0 1000 ff 1050 ff 0995 ff 1100 ff 1020 ff 0990 ff
1200 ff 1005 ff 1030 ff 0980 ff 1010 ff 1500 ff 1025 ff 1001 ff 0999 ff 1040 ff 1025 ff
1dffb 1024 46 0045 0 0 1000 0a 1050 14 0995 05 1100 1e 1020 07 0990 03
1200 40 1005 0c 1030 08 0980 11 1010 09 1500 ff 1025 06 1001 02 0999 0b 1040 0d 1025 21

// ==== src.f ====
+incdir+logic
logic/ob_book_pkg.sv
logic/ob_count_pkg.sv
logic/ob_csa_tree.sv
logic/ob_entry_select.sv
logic/ob_accum.sv
logic/ob_count_ctrl.sv
logic/ob_count_top.sv
bench/tb_clk_gen.sv
bench/tb_count_checker.sv
bench/tb_ob_count.sv

// ==== Makefile ====
# Verilator build and run of the order book count testbench

VERILATOR ?= verilator
TOP       ?= tb_ob_count
FILELIST  ?= src.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
